//--- verification/vita_timer_input.txt
# columns: op addr data lo hi, all decimal, addr is an AXI4-Lite byte address
# W writes data, R checks lo..hi (data 1 also matches the previous read), P/D/C use data
R 0 0 0 0
R 4 0 0 999
W 16 50 0 0
D 0 400 0 0
R 0 0 7 9
R 4 0 0 49
W 4 10 0 0
W 0 7000 0 0
W 12 1 0 0
R 0 0 7000 7000
R 4 0 10 49
R 0 0 7000 7001
R 4 0 0 49
R 4 1 0 49
W 4 0 0 0
W 0 0 0 0
W 12 0 0 0
C 0 0 0 0
W 0 500 0 0
R 0 0 0 499
P 0 5 0 0
D 0 10 0 0
R 0 0 500 500
C 0 1 0 0
W 8 1 0 0
W 0 900 0 0
R 0 0 0 899
P 0 5 0 0
D 0 10 0 0
R 0 0 900 900
C 0 2 0 0

//--- vita_timer_top.f
design/bus_pkg.sv
design/vita_time_pkg.sv
design/setting_reg.sv
design/pps_capture.sv
design/axil_setting_bridge.sv
design/time_64bit.sv
design/vita_timer_top.sv
verification/vita_timer_tb.sv

//--- verification/vita_timer_tb.sv
`timescale 1ns/100ps

module vita_timer_tb
   import bus_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 50;

   logic        clk;
   logic        rst;
   logic        pps;
   logic        pps_int;
   logic [63:0] vita_time;
   axil_req_t   axil_req;
   axil_rsp_t   axil_rsp;
   int          errors;
   int          checks;
   int          pps_count;
   bit          timed_out;

   vita_timer_top #(.TICKS_PER_SEC(32'd1000), .BASE(0)) dut_i (
      .clk(clk), .rst(rst), .axil_req(axil_req), .axil_rsp(axil_rsp),
      .pps(pps), .vita_time(vita_time), .pps_int(pps_int)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (!rst && pps_int)
         pps_count <= pps_count + 1; // pulses seen at the top port
   end

   function automatic logic rsp_flag(input string what);
      case (what)
         "awready": return axil_rsp.awready;
         "bvalid":  return axil_rsp.bvalid;
         "arready": return axil_rsp.arready;
         default:   return axil_rsp.rvalid;
      endcase
   endfunction

   // stops on the rising edge where the flag is high, so the handshake completes there
   task automatic wait_for(input string what);
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!timed_out && !rsp_flag(what) && n < TIMEOUT_CYCLES);
      if (!timed_out && !rsp_flag(what))
      begin
         $display("the DUT did not raise %s within %0d cycles", what, n);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk);
      axil_req.awvalid <= 1'b1;
      axil_req.awaddr  <= addr;
      axil_req.wvalid  <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.wstrb   <= 4'hf;
      axil_req.bready  <= 1'b1;
      wait_for("awready");
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      wait_for("bvalid");
      axil_req.bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge clk);
      axil_req.arvalid <= 1'b1;
      axil_req.araddr  <= addr;
      axil_req.rready  <= 1'b1;
      wait_for("arready");
      axil_req.arvalid <= 1'b0;
      wait_for("rvalid");
      data = axil_rsp.rdata;
      axil_req.rready <= 1'b0;
   endtask

   initial
   begin
      int          fd;
      int          code;
      int          line_no;
      string       line;
      string       name;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] value;
      logic [31:0] last_read;
      logic [31:0] port_secs;
      axil_req  = '0;
      pps       = 1'b0;
      rst       = 1'b1;
      errors    = 0;
      checks    = 0;
      pps_count = 0;
      timed_out = 1'b0;
      last_read = '0;
      line_no   = 0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      fd = $fopen("verification/vita_timer_input.txt", "r");
      if (fd == 0)
      begin
         $display("could not open verification/vita_timer_input.txt");
         errors++;
      end
      while (fd != 0 && !timed_out && !$feof(fd))
      begin
         code = $fgets(line, fd);
         line_no++;
         if (code > 1 && line[0] != "#")
         begin
            code = $sscanf(line, "%c %d %d %d %d", op, addr, data, lo, hi);
            if (code != 5)
               op = "?";
            name = $sformatf("%c line %0d", op, line_no);
            case (op)
               "W":
                  axil_write(addr[11:0], data);
               "R":
               begin
                  axil_read(addr[11:0], value);
                  port_secs = vita_time[63:32]; // one cycle newer than the read data
                  checks++;
                  assert (timed_out || (value >= lo && value <= hi))
                  else
                  begin
                     errors++;
                     $display("** Error: %s expected %0d to %0d, actual %0d",
                              name, lo, hi, value);
                  end
                  if (addr == 0)
                  begin
                     checks++; // the time port may have rolled over once since the read
                     assert (timed_out || (port_secs >= lo && port_secs <= hi + 1))
                     else
                     begin
                        errors++;
                        $display("** Error: %s port seconds expected %0d to %0d, actual %0d",
                                 name, lo, hi + 1, port_secs);
                     end
                  end
                  if (data != 0)
                  begin
                     checks++; // must match the read before it
                     assert (timed_out || value == last_read)
                     else
                     begin
                        errors++;
                        $display("** Error: %s expected %0d, actual %0d",
                                 name, last_read, value);
                     end
                  end
                  last_read = value;
               end
               "P":
               begin
                  @(posedge clk);
                  pps <= 1'b1;
                  repeat (data) @(posedge clk);
                  pps <= 1'b0;
               end
               "D":
                  repeat (data) @(posedge clk);
               "C":
               begin
                  checks++;
                  assert (pps_count == data)
                  else
                  begin
                     errors++;
                     $display("** Error: %s expected %0d, actual %0d", name, data, pps_count);
                  end
               end
               default:
               begin
                  $display("malformed or unknown command on line %0d of the stimulus file",
                           line_no);
                  errors++;
               end
            endcase
         end
      end
      if (fd != 0)
         $fclose(fd);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- design/vita_timer_top.sv
`timescale 1ns/100ps

module vita_timer_top
   import bus_pkg::*, vita_time_pkg::*;
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000,
   parameter int unsigned BASE          = 0
)
(
   input  logic       clk,
   input  logic       rst,
   input  axil_req_t  axil_req,
   output axil_rsp_t  axil_rsp,
   input  logic       pps,
   output vita_time_t vita_time,
   output logic       pps_int
);

   setting_bus_t setting;
   pps_ctrl_t    pps_ctrl;
   logic         pps_edge;

   axil_setting_bridge bridge_i (
      .clk       (clk),
      .rst       (rst),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .setting   (setting),
      .vita_time (vita_time)
   );

   time_64bit #(
      .TICKS_PER_SEC (TICKS_PER_SEC),
      .BASE          (BASE)
   ) time_i (
      .clk       (clk),
      .rst       (rst),
      .setting   (setting),
      .pps_edge  (pps_edge),
      .pps_ctrl  (pps_ctrl),
      .vita_time (vita_time)
   );

   pps_capture pps_i (
      .clk      (clk),
      .rst      (rst),
      .pps      (pps),
      .ctrl     (pps_ctrl),
      .pps_edge (pps_edge)
   );

   assign pps_int = pps_edge;

endmodule

//--- design/time_64bit.sv
`timescale 1ns/100ps

module time_64bit
   import bus_pkg::*, vita_time_pkg::*;
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000,
   parameter int unsigned BASE          = 0
)
(
   input  logic         clk,
   input  logic         rst,
   input  setting_bus_t setting,
   input  logic         pps_edge,
   output pps_ctrl_t    pps_ctrl,
   output vita_time_t   vita_time
);

   logic [31:0] next_secs;
   logic [31:0] next_ticks;
   logic [31:0] tps;
   logic        set_imm;
   logic        arm_stb;
   logic        armed;
   logic        load_evt;
   logic [31:0] ticks_plus_one;
   vita_time_t  time_q;

   setting_reg #(.my_addr(8'(BASE + REG_NEXT_SECS)), .width(32), .at_reset(32'd0))
      next_secs_reg_i
      (.clk(clk), .rst(rst), .setting(setting), .out(next_secs), .changed(arm_stb));

   setting_reg #(.my_addr(8'(BASE + REG_NEXT_TICKS)), .width(32), .at_reset(32'd0))
      next_ticks_reg_i
      (.clk(clk), .rst(rst), .setting(setting), .out(next_ticks), .changed());

   setting_reg #(.my_addr(8'(BASE + REG_PPS_CTRL)), .width(PPS_CTRL_W), .at_reset('0))
      pps_ctrl_reg_i
      (.clk(clk), .rst(rst), .setting(setting), .out(pps_ctrl), .changed());

   setting_reg #(.my_addr(8'(BASE + REG_PPS_IMM)), .width(1), .at_reset(1'b0))
      pps_imm_reg_i
      (.clk(clk), .rst(rst), .setting(setting), .out(set_imm), .changed());

   setting_reg #(.my_addr(8'(BASE + REG_TPS)), .width(32), .at_reset(TICKS_PER_SEC))
      tps_reg_i
      (.clk(clk), .rst(rst), .setting(setting), .out(tps), .changed());

   assign load_evt = armed & (set_imm | pps_edge);

   // an unarmed pps or immediate flag also clears the flag
   always_ff @(posedge clk)
   begin
      if (rst)
         armed <= 1'b0;
      else if (arm_stb)
         armed <= 1'b1;
      else if (set_imm | pps_edge)
         armed <= 1'b0;
   end

   assign ticks_plus_one = time_q.ticks + 32'd1;

   always_ff @(posedge clk)
   begin
      if (rst)
         time_q <= '0;
      else if (load_evt)
      begin
         time_q.seconds <= next_secs;
         time_q.ticks   <= next_ticks;
      end
      else if (ticks_plus_one == tps)
      begin
         time_q.seconds <= time_q.seconds + 32'd1;
         time_q.ticks   <= '0;
      end
      else
         time_q.ticks <= ticks_plus_one;
   end

   assign vita_time = time_q;

   tps_nonzero_a: assert property (@(posedge clk) disable iff (rst) tps != '0)
      else $error("ticks-per-second set to zero");

endmodule

//--- design/axil_setting_bridge.sv
`timescale 1ns/100ps

module axil_setting_bridge
   import bus_pkg::*, vita_time_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  axil_req_t    axil_req,
   output axil_rsp_t    axil_rsp,
   output setting_bus_t setting,
   input  vita_time_t   vita_time
);

   logic        wr_ready;
   logic        bvalid;
   logic        rd_ready;
   logic        rvalid;
   logic        wr_accept;
   logic        rd_accept;
   logic        stb;
   logic [7:0]  stb_addr;
   logic [31:0] stb_data;
   logic [31:0] rdata;
   logic [31:0] ticks_snap;
   logic [7:0]  rd_word;

   assign wr_accept = wr_ready & axil_req.awvalid & axil_req.wvalid;
   assign rd_accept = rd_ready & axil_req.arvalid;
   assign rd_word   = axil_req.araddr[9:2]; // byte address to word offset

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ready <= 1'b0;
         bvalid   <= 1'b0;
         stb      <= 1'b0;
      end
      else
      begin
         wr_ready <= axil_req.awvalid & axil_req.wvalid & ~bvalid & ~wr_ready;
         stb      <= wr_accept; // stroke goes out the cycle after the handshake
         if (wr_accept)
            bvalid <= 1'b1;
         else if (axil_req.bready)
            bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_accept)
      begin
         stb_addr <= axil_req.awaddr[9:2];
         stb_data <= axil_req.wdata; // strobes are ignored, whole word replaced
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd_ready <= 1'b0;
         rvalid   <= 1'b0;
      end
      else
      begin
         rd_ready <= axil_req.arvalid & ~rvalid & ~rd_ready;
         if (rd_accept)
            rvalid <= 1'b1;
         else if (axil_req.rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         case (rd_word)
            8'(RD_TIME_SECS):
            begin
               rdata      <= vita_time.seconds;
               ticks_snap <= vita_time.ticks; // keeps the pair coherent
            end
            8'(RD_TIME_TICKS):
               rdata <= ticks_snap;
            default:
               rdata <= '0;
         endcase
      end
   end

   always_comb
   begin
      axil_rsp         = '0;
      axil_rsp.awready = wr_ready;
      axil_rsp.wready  = wr_ready;
      axil_rsp.bvalid  = bvalid;
      axil_rsp.bresp   = RESP_OKAY;
      axil_rsp.arready = rd_ready;
      axil_rsp.rvalid  = rvalid;
      axil_rsp.rdata   = rdata;
      axil_rsp.rresp   = RESP_OKAY;
   end

   assign setting.stb  = stb;
   assign setting.addr = stb_addr;
   assign setting.data = stb_data;

   bvalid_hold_a: assert property (@(posedge clk) disable iff (rst)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold_a: assert property (@(posedge clk) disable iff (rst)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
      else $error("rvalid dropped before rready");

endmodule

//--- design/pps_capture.sv
`timescale 1ns/100ps

module pps_capture
   import vita_time_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      pps,
   input  pps_ctrl_t ctrl,
   output logic      pps_edge
);

   logic       pps_pos;
   logic       pps_neg;
   logic       pps_sel;
   logic [1:0] pps_del;

   always_ff @(posedge clk)
   begin
      pps_pos <= pps;
   end

   // the falling-edge sample gives half a cycle more margin on a late PPS
   always_ff @(negedge clk)
   begin
      pps_neg <= pps;
   end

   assign pps_sel = ctrl.sample_rising ? pps_pos : pps_neg;

   always_ff @(posedge clk)
   begin
      if (rst)
         pps_del <= 2'b00;
      else
         pps_del <= {pps_del[0], pps_sel};
   end

   assign pps_edge = pps_del[0] & ~pps_del[1]; // low to high step

   pps_edge_single_a: assert property (@(posedge clk) disable iff (rst)
      pps_edge |=> !pps_edge)
      else $error("pps_edge high for more than one cycle");

endmodule

//--- design/setting_reg.sv
`timescale 1ns/100ps

module setting_reg
   import bus_pkg::*;
#(
   parameter logic [7:0]       my_addr  = 8'd0,
   parameter int unsigned      width    = 32,
   parameter logic [width-1:0] at_reset = '0
)
(
   input  logic             clk,
   input  logic             rst,
   input  setting_bus_t     setting,
   output logic [width-1:0] out,
   output logic             changed
);

   logic hit;

   assign hit = setting.stb && (setting.addr == my_addr);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out     <= at_reset;
         changed <= 1'b0;
      end
      else
      begin
         changed <= hit; // lines up with the new value on out
         if (hit)
            out <= setting.data[width-1:0];
      end
   end

endmodule

//--- design/vita_time_pkg.sv
package vita_time_pkg;

   // 64-bit time value, whole seconds above ticks within the second
   typedef struct packed
   {
      logic [31:0] seconds;
      logic [31:0] ticks;
   } vita_time_t;

   // setting-bus word offsets, added to BASE by the time keeper
   localparam int unsigned REG_NEXT_SECS  = 0; // a write here arms the preset
   localparam int unsigned REG_NEXT_TICKS = 1;
   localparam int unsigned REG_PPS_CTRL   = 2;
   localparam int unsigned REG_PPS_IMM    = 3; // load at once instead of on PPS
   localparam int unsigned REG_TPS        = 4;

   // word offsets of the read space
   localparam int unsigned RD_TIME_SECS  = 0; // also snapshots the ticks word
   localparam int unsigned RD_TIME_TICKS = 1;

   // PPS control word, bit 0 of REG_PPS_CTRL
   typedef struct packed
   {
      logic sample_rising; // 1 samples pps on the rising clock edge
   } pps_ctrl_t;

   localparam int unsigned PPS_CTRL_W = $bits(pps_ctrl_t);

endpackage

//--- design/bus_pkg.sv
package bus_pkg;

   localparam int unsigned AXIL_ADDR_W = 12;
   localparam int unsigned AXIL_DATA_W = 32;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // AXI4-Lite master to slave
   typedef struct packed
   {
      logic                     awvalid;
      logic [AXIL_ADDR_W-1:0]   awaddr;
      logic                     wvalid;
      logic [AXIL_DATA_W-1:0]   wdata;
      logic [AXIL_DATA_W/8-1:0] wstrb;
      logic                     bready;
      logic                     arvalid;
      logic [AXIL_ADDR_W-1:0]   araddr;
      logic                     rready;
   } axil_req_t;

   // AXI4-Lite slave to master
   typedef struct packed
   {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      logic [1:0]             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
   } axil_rsp_t;

   // one-cycle register write stroke, addr is a word address
   typedef struct packed
   {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } setting_bus_t;

endpackage
